//--- src/add_unit.sv
// Adder unit of the lane: add, subtract and compare.
// Takes the resolved operands, claims its own op codes and registers
// result, flags, write enable and valid one cycle later.
// Subtract and compare use A + ~B + 1.

`timescale 1ns/1ps

module add_unit import alu_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  logic [OP_W-1:0]   op,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic              valid,
  output logic [DATA_W-1:0] data,
  output logic [FLAG_W-1:0] flags,
  output logic              wr_en
);

  logic              is_sub;
  logic              is_cmp;
  logic              claim;
  logic [DATA_W-1:0] b_eff;
  logic [DATA_W:0]   sum;
  logic [FLAG_W-1:0] flags_nxt;

  assign is_cmp = (op == OP_CMP);
  assign is_sub = (op == OP_SUB) || is_cmp;
  assign claim  = in_valid && ((op == OP_ADD) || is_sub);

  assign b_eff = is_sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, is_sub};

  always_comb begin
    flags_nxt         = '0;
    flags_nxt[FLAG_Z] = (sum[DATA_W-1:0] == '0);
    flags_nxt[FLAG_S] = sum[DATA_W-1];
    flags_nxt[FLAG_C] = sum[DATA_W]; // No borrow when subtracting.
    flags_nxt[FLAG_V] = (a[DATA_W-1] == b_eff[DATA_W-1]) &&
                        (sum[DATA_W-1] != a[DATA_W-1]);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= 1'b0;
      wr_en <= 1'b0;
      data  <= '0;
      flags <= '0;
    end else begin
      valid <= claim;
      wr_en <= claim && !is_cmp; // Compare only sets flags.
      if (claim) begin
        data  <= sum[DATA_W-1:0];
        flags <= flags_nxt;
      end
    end
  end

  a_op_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    in_valid |-> !$isunknown(op)
  ) else $error("add_unit: unknown op with in_valid");

endmodule

//--- src/alu_lane.sv
// Top level of one integer ALU lane.
// Two operand bypasses feed the adder and shifter side by side; the
// merge stage registers the finished result. Latency is two cycles,
// one operation accepted per cycle.

`timescale 1ns/1ps

module alu_lane #(
  parameter int DATA_W = 64
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,
  input  logic [alu_pkg::OP_W-1:0]  op,
  input  logic [DATA_W-1:0]         a_reg,
  input  logic [DATA_W-1:0]         b_reg,
  input  logic [alu_pkg::SEL_W-1:0] a_sel,
  input  logic [alu_pkg::SEL_W-1:0] b_sel,
  input  logic [DATA_W-1:0]         res_bus,
  output logic                      out_valid,
  output logic [DATA_W-1:0]         out_data,
  output logic [alu_pkg::FLAG_W-1:0] out_flags,
  output logic                      out_wr_en
);

  logic [DATA_W-1:0]          a_op;
  logic [DATA_W-1:0]          b_op;
  logic                       add_valid;
  logic [DATA_W-1:0]          add_data;
  logic [alu_pkg::FLAG_W-1:0] add_flags;
  logic                       add_wr_en;
  logic                       sh_valid;
  logic [DATA_W-1:0]          sh_data;
  logic [alu_pkg::FLAG_W-1:0] sh_flags;
  logic                       sh_wr_en;

  operand_bypass #(.DATA_W(DATA_W)) a_bypass (
    .clk(clk), .arst_n(arst_n), .reg_val(a_reg), .res_bus(res_bus),
    .sel(a_sel), .operand(a_op)
  );

  operand_bypass #(.DATA_W(DATA_W)) b_bypass (
    .clk(clk), .arst_n(arst_n), .reg_val(b_reg), .res_bus(res_bus),
    .sel(b_sel), .operand(b_op)
  );

  add_unit #(.DATA_W(DATA_W)) add_unit (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .op(op), .a(a_op), .b(b_op),
    .valid(add_valid), .data(add_data), .flags(add_flags), .wr_en(add_wr_en)
  );

  shift_unit #(.DATA_W(DATA_W)) shift_unit (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .op(op), .a(a_op), .b(b_op),
    .valid(sh_valid), .data(sh_data), .flags(sh_flags), .wr_en(sh_wr_en)
  );

  result_merge #(.DATA_W(DATA_W)) result_merge (
    .clk(clk), .arst_n(arst_n),
    .add_valid(add_valid), .add_data(add_data), .add_flags(add_flags),
    .add_wr_en(add_wr_en),
    .sh_valid(sh_valid), .sh_data(sh_data), .sh_flags(sh_flags), .sh_wr_en(sh_wr_en),
    .out_valid(out_valid), .out_data(out_data), .out_flags(out_flags),
    .out_wr_en(out_wr_en)
  );

endmodule

//--- src/alu_pkg.sv
// Shared constants for the integer ALU lane.
// Operation codes, flag bit positions and select encodings used by
// the bypass muxes, the execution units and the testbench.

package alu_pkg;

  // Operation code.
  localparam int OP_W = 8;

  localparam logic [OP_W-1:0] OP_ADD = 8'h10;
  localparam logic [OP_W-1:0] OP_SUB = 8'h11;
  localparam logic [OP_W-1:0] OP_CMP = 8'h12; // Subtract, no writeback.
  localparam logic [OP_W-1:0] OP_SHL = 8'h20;
  localparam logic [OP_W-1:0] OP_SHR = 8'h21;
  localparam logic [OP_W-1:0] OP_SAR = 8'h22; // Sign fill.

  // Flag word layout.
  localparam int FLAG_W = 4;

  localparam int FLAG_Z = 0; // Zero.
  localparam int FLAG_S = 1; // Sign.
  localparam int FLAG_C = 2; // Carry, no-borrow for subtract.
  localparam int FLAG_V = 3; // Signed overflow.

  // Operand source select.
  localparam int SEL_W = 2;

  localparam logic [SEL_W-1:0] SEL_REG      = 2'd0;
  localparam logic [SEL_W-1:0] SEL_BUS      = 2'd1;
  localparam logic [SEL_W-1:0] SEL_BUS_PREV = 2'd2;

endpackage

//--- src/operand_bypass.sv
// Source operand select for one ALU input.
// Picks the register file value, the live result bus or the result
// bus as it was one cycle earlier. One instance per operand.

`timescale 1ns/1ps

module operand_bypass import alu_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [DATA_W-1:0] reg_val,
  input  logic [DATA_W-1:0] res_bus,
  input  logic [SEL_W-1:0]  sel,
  output logic [DATA_W-1:0] operand
);

  logic [DATA_W-1:0] bus_prev;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus_prev <= '0;
    end else begin
      bus_prev <= res_bus; // One cycle behind the bus.
    end
  end

  always_comb begin
    case (sel)
      SEL_BUS:      operand = res_bus;
      SEL_BUS_PREV: operand = bus_prev;
      default:      operand = reg_val;
    endcase
  end

  // The scheduler never issues select 3; the lane's valid is not
  // visible here, so the check runs on every cycle.
  a_sel_legal: assert property (
    @(posedge clk) disable iff (!arst_n)
    sel != 2'd3
  ) else $error("operand_bypass: illegal source select %0d", sel);

endmodule

//--- src/result_merge.sv
// Output stage of the lane.
// Registers the bundle of whichever unit finished this cycle; idle
// cycles drop valid and write enable and keep the last data.

`timescale 1ns/1ps

module result_merge import alu_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              add_valid,
  input  logic [DATA_W-1:0] add_data,
  input  logic [FLAG_W-1:0] add_flags,
  input  logic              add_wr_en,
  input  logic              sh_valid,
  input  logic [DATA_W-1:0] sh_data,
  input  logic [FLAG_W-1:0] sh_flags,
  input  logic              sh_wr_en,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  output logic [FLAG_W-1:0] out_flags,
  output logic              out_wr_en
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_wr_en <= 1'b0;
      out_data  <= '0;
      out_flags <= '0;
    end else if (add_valid) begin
      out_valid <= 1'b1;
      out_wr_en <= add_wr_en;
      out_data  <= add_data;
      out_flags <= add_flags;
    end else if (sh_valid) begin
      out_valid <= 1'b1;
      out_wr_en <= sh_wr_en;
      out_data  <= sh_data;
      out_flags <= sh_flags;
    end else begin
      out_valid <= 1'b0;
      out_wr_en <= 1'b0; // Data held.
    end
  end

  // Op decode in the two units must be disjoint.
  a_one_unit: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(add_valid && sh_valid)
  ) else $error("result_merge: adder and shifter valid together");

endmodule

//--- src/shift_unit.sv
// Shifter unit of the lane: logical left, logical right, arithmetic right.
// The amount is the low log2(DATA_W) bits of b. Operands are widened
// by one bit so the last bit shifted out falls into the carry position.

`timescale 1ns/1ps

module shift_unit import alu_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  logic [OP_W-1:0]   op,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic              valid,
  output logic [DATA_W-1:0] data,
  output logic [FLAG_W-1:0] flags,
  output logic              wr_en
);

  localparam int SH_W = $clog2(DATA_W);

  logic [SH_W-1:0]   amt;
  logic              claim;
  logic [DATA_W:0]   shl_ext;
  logic [DATA_W:0]   shr_ext;
  logic [DATA_W:0]   sar_ext;
  logic [DATA_W-1:0] res;
  logic              carry;
  logic [FLAG_W-1:0] flags_nxt;

  assign amt   = b[SH_W-1:0];
  assign claim = in_valid && ((op == OP_SHL) || (op == OP_SHR) || (op == OP_SAR));

  assign shl_ext = {1'b0, a} << amt;          // Carry lands in the top bit.
  assign shr_ext = {a, 1'b0} >> amt;          // Carry lands in bit 0.
  assign sar_ext = $signed({a, 1'b0}) >>> amt;

  always_comb begin
    case (op)
      OP_SHL:  {carry, res} = shl_ext;
      OP_SAR:  {res, carry} = sar_ext;
      default: {res, carry} = shr_ext;
    endcase
    flags_nxt         = '0;
    flags_nxt[FLAG_Z] = (res == '0);
    flags_nxt[FLAG_S] = res[DATA_W-1];
    flags_nxt[FLAG_C] = carry; // Zero for a zero amount.
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= 1'b0;
      wr_en <= 1'b0;
      data  <= '0;
      flags <= '0;
    end else begin
      valid <= claim;
      wr_en <= claim;
      if (claim) begin
        data  <= res;
        flags <= flags_nxt;
      end
    end
  end

endmodule

//--- tb.f
src/alu_pkg.sv
src/operand_bypass.sv
src/add_unit.sv
src/shift_unit.sv
src/result_merge.sv
src/alu_lane.sv
verification/clk_gen.sv
verification/alu_lane_tb.sv

//--- verification/alu_lane_tb.sv
// Self-checking testbench for the ALU lane.
// Drives random and fixed operations, keeps its own result bus history
// for operand resolution and checks every output against a reference.

`timescale 1ns/1ps

module alu_lane_tb import alu_pkg::*;;

  localparam int DATA_W = 64;
  localparam int SH_W   = $clog2(DATA_W);
  localparam int RESET_CYCLES = 5;
  localparam int N_ARITH  = 40;
  localparam int N_SHIFT  = 40;
  localparam int N_BYPASS = 40;
  localparam int N_MIXED  = 60;
  localparam int N_EDGE   = 8;
  localparam int N_OPS    = N_ARITH + N_SHIFT + N_BYPASS + N_MIXED + N_EDGE;
  localparam int CYCLE_LIMIT = (N_OPS + RESET_CYCLES + 2) * 2 + 20;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic              clk;
  logic              arst_n;
  logic              in_valid;
  logic [OP_W-1:0]   op;
  logic [DATA_W-1:0] a_reg;
  logic [DATA_W-1:0] b_reg;
  logic [SEL_W-1:0]  a_sel;
  logic [SEL_W-1:0]  b_sel;
  logic [DATA_W-1:0] res_bus;
  logic              out_valid;
  logic [DATA_W-1:0] out_data;
  logic [FLAG_W-1:0] out_flags;
  logic              out_wr_en;

  logic [31:0]       lfsr_state = 32'd51;
  logic [DATA_W-1:0] bus_prev_val;
  int                cycle = 0;
  logic [OP_W-1:0]   all_ops [6] = '{OP_ADD, OP_SUB, OP_CMP, OP_SHL, OP_SHR, OP_SAR};

  logic [DATA_W-1:0] exp_data_q [$];
  logic [FLAG_W-1:0] exp_flags_q [$];
  logic              exp_wr_q [$];
  int                accept_q [$];

  clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) clocks (.clk(clk), .arst_n(arst_n));

  alu_lane #(.DATA_W(DATA_W)) DUT (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .op(op),
    .a_reg(a_reg), .b_reg(b_reg), .a_sel(a_sel), .b_sel(b_sel), .res_bus(res_bus),
    .out_valid(out_valid), .out_data(out_data), .out_flags(out_flags),
    .out_wr_en(out_wr_en)
  );

  // One LFSR step per bit taken.
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (lsb ? LFSR_TAPS : 32'd0);
      val        = {val[62:0], lsb};
    end
    return val;
  endfunction

  function automatic logic [DATA_W-1:0] pick_operand(input logic [SEL_W-1:0] sel,
                                                     input logic [DATA_W-1:0] reg_val);
    case (sel)
      SEL_BUS:      return res_bus;
      SEL_BUS_PREV: return bus_prev_val;
      default:      return reg_val;
    endcase
  endfunction

  function automatic void expected_result(input logic [OP_W-1:0] o,
                                          input logic [DATA_W-1:0] a,
                                          input logic [DATA_W-1:0] b,
                                          output logic [DATA_W-1:0] d,
                                          output logic [FLAG_W-1:0] f,
                                          output logic w);
    int            amt;
    logic          c;
    logic          v;
    logic [DATA_W:0] wide;
    amt = b[SH_W-1:0];
    c   = 1'b0;
    v   = 1'b0;
    w   = 1'b1;
    case (o)
      OP_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        d    = wide[DATA_W-1:0];
        c    = wide[DATA_W];
        v    = (a[DATA_W-1] == b[DATA_W-1]) && (d[DATA_W-1] != a[DATA_W-1]);
      end
      OP_SUB, OP_CMP: begin
        d = a - b;
        c = (a >= b); // No borrow.
        v = (a[DATA_W-1] != b[DATA_W-1]) && (d[DATA_W-1] != a[DATA_W-1]);
        w = (o != OP_CMP);
      end
      OP_SHL: begin
        d = a << amt;
        if (amt != 0) c = a[DATA_W-amt];
      end
      OP_SHR: begin
        d = a >> amt;
        if (amt != 0) c = a[amt-1];
      end
      default: begin
        d = $signed(a) >>> amt;
        if (amt != 0) c = a[amt-1];
      end
    endcase
    f         = '0;
    f[FLAG_Z] = (d == '0);
    f[FLAG_S] = d[DATA_W-1];
    f[FLAG_C] = c;
    f[FLAG_V] = v;
  endfunction

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "Data mismatch.");
    end
  endtask

  task automatic check_flags(input string name, input logic [FLAG_W-1:0] exp,
                             input logic [FLAG_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "Flag mismatch.");
    end
  endtask

  task automatic check_wr(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "Control bit mismatch.");
    end
  endtask

  // Drives one cycle 1 ns after the edge; queues the expected result.
  task automatic issue_op(input logic v, input logic [OP_W-1:0] o,
                          input logic [DATA_W-1:0] ar, input logic [DATA_W-1:0] br,
                          input logic [SEL_W-1:0] as, input logic [SEL_W-1:0] bs);
    logic [DATA_W-1:0] d;
    logic [FLAG_W-1:0] f;
    logic              w;
    @(posedge clk);
    #1;
    bus_prev_val = res_bus;
    res_bus      = lfsr_bits(DATA_W);
    in_valid     = v;
    op           = o;
    a_reg        = ar;
    b_reg        = br;
    a_sel        = as;
    b_sel        = bs;
    if (v) begin
      expected_result(o, pick_operand(as, ar), pick_operand(bs, br), d, f, w);
      exp_data_q.push_back(d);
      exp_flags_q.push_back(f);
      exp_wr_q.push_back(w);
      accept_q.push_back(cycle + 1);
    end
  endtask

  task automatic idle_cycle();
    issue_op(1'b0, OP_ADD, lfsr_bits(DATA_W), lfsr_bits(DATA_W), SEL_REG, SEL_REG);
  endtask

  task automatic arith_stream();
    for (int i = 0; i < N_ARITH; i++) begin
      issue_op(1'b1, all_ops[lfsr_bits(2) % 3], lfsr_bits(DATA_W), lfsr_bits(DATA_W),
               SEL_REG, SEL_REG);
    end
  endtask

  task automatic shift_sweep();
    logic [DATA_W-1:0] b;
    for (int i = 0; i < N_SHIFT; i++) begin
      b = lfsr_bits(DATA_W);
      if (i < 6) b[SH_W-1:0] = (i % 2 == 0) ? '0 : SH_W'(DATA_W - 1); // Amount extremes.
      issue_op(1'b1, all_ops[3 + (i < 6 ? i / 2 : lfsr_bits(2) % 3)], lfsr_bits(DATA_W), b,
               SEL_REG, SEL_REG);
    end
  endtask

  task automatic bypass_mix();
    logic [SEL_W-1:0] as;
    logic [SEL_W-1:0] bs;
    for (int i = 0; i < N_BYPASS; i++) begin
      as = SEL_W'(lfsr_bits(2) % 3);
      bs = SEL_W'(lfsr_bits(2) % 3);
      issue_op(1'b1, all_ops[lfsr_bits(3) % 6], lfsr_bits(DATA_W), lfsr_bits(DATA_W), as, bs);
    end
  endtask

  task automatic gapped_stream();
    for (int i = 0; i < N_MIXED; i++) begin
      if (lfsr_bits(2) == 0) idle_cycle();
      issue_op(1'b1, all_ops[lfsr_bits(3) % 6], lfsr_bits(DATA_W), lfsr_bits(DATA_W),
               SEL_REG, SEL_REG);
    end
  endtask

  task automatic edge_values();
    logic [DATA_W-1:0] ones;
    logic [DATA_W-1:0] min_neg;
    ones    = '1;
    min_neg = {1'b1, {(DATA_W-1){1'b0}}};
    issue_op(1'b1, OP_ADD, '0, '0, SEL_REG, SEL_REG);          // Zero, no carry.
    issue_op(1'b1, OP_ADD, ones, 1, SEL_REG, SEL_REG);         // Wraps to zero.
    issue_op(1'b1, OP_SUB, ones, ones, SEL_REG, SEL_REG);      // Equal, no borrow.
    issue_op(1'b1, OP_SUB, '0, 1, SEL_REG, SEL_REG);           // Borrow.
    issue_op(1'b1, OP_SUB, min_neg, 1, SEL_REG, SEL_REG);      // Signed overflow.
    issue_op(1'b1, OP_CMP, min_neg, 1, SEL_REG, SEL_REG);
    issue_op(1'b1, OP_SAR, min_neg, DATA_W - 1, SEL_REG, SEL_REG);
    issue_op(1'b1, OP_SHL, ones, 1, SEL_REG, SEL_REG);
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles.", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $fatal(1, "Timeout.");
    end
  end

  // Outputs are sampled on the falling edge, where they are stable.
  always @(negedge clk) begin : compare
    int accepted;
    if (arst_n !== 1'b1 || out_valid !== 1'b1) begin
      check_wr("out_valid", 1'b0, out_valid);
      check_wr("out_wr_en", 1'b0, out_wr_en);
    end else if (exp_data_q.size() == 0) begin
      $display("Output at time %0t with no operation outstanding.", $time);
      $display("*** FAILED ***");
      $fatal(1, "Unexpected output.");
    end else begin
      accepted = accept_q.pop_front();
      if (cycle + 1 != accepted + 2) begin // Taken at the next rising edge.
        $display("Output at time %0t came %0d cycles after acceptance instead of 2.",
                 $time, cycle + 1 - accepted);
        $display("*** FAILED ***");
        $fatal(1, "Latency error.");
      end else begin
        check_data("out_data", exp_data_q.pop_front(), out_data);
        check_flags("out_flags", exp_flags_q.pop_front(), out_flags);
        check_wr("out_wr_en", exp_wr_q.pop_front(), out_wr_en);
      end
    end
  end

  initial begin
    in_valid     = 1'b0;
    op           = OP_ADD;
    a_reg        = '0;
    b_reg        = '0;
    a_sel        = SEL_REG;
    b_sel        = SEL_REG;
    res_bus      = '0;
    bus_prev_val = '0;
    @(posedge arst_n);
    idle_cycle();
    check_wr("out_valid", 1'b0, out_valid); // First edge after reset.
    check_wr("out_wr_en", 1'b0, out_wr_en);
    idle_cycle();
    arith_stream();
    shift_sweep();
    bypass_mix();
    gapped_stream();
    edge_values();
    repeat (4) idle_cycle();
    if (exp_data_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("%0d operations never produced an output.", exp_data_q.size());
      $display("*** FAILED ***");
      $fatal(1, "Missing outputs.");
    end
  end

endmodule

//--- verification/clk_gen.sv
// Clock and reset source for the ALU lane testbench.
// Free-running clock; reset held low for a fixed number of rising edges.

`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 arst_n = 1'b1; // Clear of both clock edges.
  end

endmodule
